//--- cache_rd_top.f
hdl/cache_pkg.sv
hdl/line_refill.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_ctrl.sv
hdl/cache_rd_top.sv
tb/cache_rd_checker.sv
tb/cache_rd_tb.sv

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
   input  logic               clk_i,
   input  logic               reset,
   input  logic               req,
   input  fe_addr_u           addr,
   input  logic               invalidate,
   output logic               busy,
   output logic               rvalid,
   input  logic               hit,
   output logic [INDEX_W-1:0] lookup_index,
   output logic [TAG_W-1:0]   lookup_tag,
   output logic               fill,
   output logic               replace_valid,
   input  logic               replace,
   output fe_addr_u           req_addr,
   output logic               rd_en
);

   logic [2:0] state;
   logic       refill_started;  // refill channel has picked up the request

   always_ff @(posedge clk_i) begin
      if ((state == CT_IDLE) && req) begin
         req_addr <= addr;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state          <= CT_IDLE;
         rvalid         <= 1'b0;
         refill_started <= 1'b0;
      end else begin
         rvalid         <= (state == CT_ANSWER);  // answer lands one cycle after
         refill_started <= (state == CT_REFILL) && (refill_started || replace);
         case (state)
            CT_IDLE: begin
               if (req) begin
                  state <= CT_LOOKUP;
               end
            end
            CT_LOOKUP: begin
               state <= hit ? CT_ANSWER : CT_REFILL;
            end
            CT_REFILL: begin
               if (refill_started && !replace) begin  // line written so the tag is set now
                  state <= CT_REREAD;
               end
            end
            CT_REREAD: begin
               state <= CT_ANSWER;
            end
            CT_ANSWER: begin
               state <= CT_IDLE;
            end
            default: begin
               state <= CT_IDLE;
            end
         endcase
      end
   end

   assign busy          = (state != CT_IDLE);
   assign lookup_index  = req_addr.f.index;
   assign lookup_tag    = req_addr.f.tag;
   assign replace_valid = (state == CT_REFILL) && !refill_started && !replace;
   assign fill          = (state == CT_REFILL) && refill_started && !replace;
   assign rd_en         = (state == CT_LOOKUP) || (state == CT_REREAD);  // store read

   a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (reset)
      rvalid |=> !rvalid)
      else $error("rvalid held longer than one cycle");

   a_req_ignored_busy: assert property (@(posedge clk_i) disable iff (reset)
      (busy && req) |=> $stable(req_addr))
      else $error("request accepted while busy");

   // an invalidate taken with a request flushes before that request's lookup
   a_inval_then_miss: assert property (@(posedge clk_i) disable iff (reset)
      (!busy && req && invalidate) |=> !hit)
      else $error("lookup hit right after invalidate");

endmodule

//--- hdl/cache_pkg.sv
package cache_pkg;

   localparam int FE_ADDR_W     = 16;
   localparam int FE_DATA_W     = 32;
   localparam int BE_ADDR_W     = 16;
   localparam int BE_DATA_W     = 64;
   localparam int WORD_OFFSET_W = 3;  // 8 front-end words per line
   localparam int LINE2BE_W     = 2;  // 4 back-end words per line
   localparam int INDEX_W       = 4;  // 16 lines
   localparam int FE_BYTE_W     = 2;
   localparam int BE_NBYTES_W   = 3;
   localparam int TAG_W         = FE_ADDR_W - INDEX_W - WORD_OFFSET_W - FE_BYTE_W;
   localparam int LINE_ADDR_W   = TAG_W + INDEX_W;
   localparam int N_LINES       = 1 << INDEX_W;
   localparam int STORE_DEPTH   = 1 << (INDEX_W + LINE2BE_W);  // back-end words held

   // refill channel states
   localparam logic [1:0] RF_IDLE          = 2'd0;
   localparam logic [1:0] RF_HANDSHAKE     = 2'd1;
   localparam logic [1:0] RF_END_HANDSHAKE = 2'd2;

   // request sequencer states
   localparam logic [2:0] CT_IDLE   = 3'd0;
   localparam logic [2:0] CT_LOOKUP = 3'd1;
   localparam logic [2:0] CT_REFILL = 3'd2;
   localparam logic [2:0] CT_REREAD = 3'd3;
   localparam logic [2:0] CT_ANSWER = 3'd4;

   typedef struct packed {
      logic [TAG_W-1:0]         tag;
      logic [INDEX_W-1:0]       index;
      logic [WORD_OFFSET_W-1:0] word;
      logic [FE_BYTE_W-1:0]     byte_sel;
   } fe_fields_t;

   typedef struct packed {
      logic [LINE_ADDR_W-1:0]   line;
      logic [WORD_OFFSET_W-1:0] word;
      logic [FE_BYTE_W-1:0]     byte_sel;
   } fe_line_t;

   // same address word seen as lookup fields or as a line number
   typedef union packed {
      fe_fields_t f;
      fe_line_t   l;
   } fe_addr_u;

endpackage

//--- hdl/cache_rd_top.sv
`timescale 1ns/1ps

module cache_rd_top import cache_pkg::*; (
   input  logic                 clk_i,
   input  logic                 reset,
   input  logic                 req,
   input  logic [FE_ADDR_W-1:0] addr,
   input  logic                 invalidate,
   output logic                 busy,
   output logic [FE_DATA_W-1:0] rdata,
   output logic                 rvalid,
   output logic [BE_ADDR_W-1:0] be_addr,
   output logic                 be_valid,
   input  logic                 be_ready,
   input  logic                 be_rvalid,
   input  logic [BE_DATA_W-1:0] be_rdata
);

   fe_addr_u             req_addr;
   logic                 hit;
   logic                 fill;
   logic                 inval_live;
   logic [INDEX_W-1:0]   lookup_index;
   logic [TAG_W-1:0]     lookup_tag;
   logic                 replace_valid;
   logic                 replace;
   logic                 rd_en;
   logic                 read_valid;
   logic [LINE2BE_W-1:0] read_addr;
   logic [BE_DATA_W-1:0] read_rdata;

   assign inval_live = invalidate & ~busy;  // flush only between requests

   cache_ctrl u_ctrl (
      .clk_i         (clk_i),
      .reset         (reset),
      .req           (req),
      .addr          (addr),
      .invalidate    (invalidate),
      .busy          (busy),
      .rvalid        (rvalid),
      .hit           (hit),
      .lookup_index  (lookup_index),
      .lookup_tag    (lookup_tag),
      .fill          (fill),
      .replace_valid (replace_valid),
      .replace       (replace),
      .req_addr      (req_addr),
      .rd_en         (rd_en)
   );

   tag_store u_tags (
      .clk_i      (clk_i),
      .reset      (reset),
      .invalidate (inval_live),
      .index      (lookup_index),
      .tag        (lookup_tag),
      .fill       (fill),
      .hit        (hit)
   );

   data_store u_data (
      .clk_i    (clk_i),
      .wr_en    (read_valid),
      .wr_index (req_addr.f.index),
      .wr_word  (read_addr),
      .wr_data  (read_rdata),
      .rd_en    (rd_en),
      .rd_addr  (req_addr),
      .rd_data  (rdata)
   );

   line_refill u_refill (
      .clk_i         (clk_i),
      .reset         (reset),
      .replace_valid (replace_valid),
      .replace_addr  (req_addr),
      .replace       (replace),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .be_addr       (be_addr),
      .be_valid      (be_valid),
      .be_ready      (be_ready),
      .be_rvalid     (be_rvalid),
      .be_rdata      (be_rdata)
   );

endmodule

//--- hdl/data_store.sv
`timescale 1ns/1ps

module data_store import cache_pkg::*; (
   input  logic                 clk_i,
   input  logic                 wr_en,
   input  logic [INDEX_W-1:0]   wr_index,
   input  logic [LINE2BE_W-1:0] wr_word,
   input  logic [BE_DATA_W-1:0] wr_data,
   input  logic                 rd_en,
   input  fe_addr_u             rd_addr,
   output logic [FE_DATA_W-1:0] rd_data
);

   logic [BE_DATA_W-1:0] mem [STORE_DEPTH];
   logic [BE_DATA_W-1:0] be_word;

   // refill writes a whole back-end word per returned beat
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[{wr_index, wr_word}] <= wr_data;
      end
   end

   // upper word-offset bits pick the back-end word within the line
   assign be_word = mem[{rd_addr.f.index, rd_addr.f.word[WORD_OFFSET_W-1:1]}];

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         if (rd_addr.f.word[0]) begin
            rd_data <= be_word[BE_DATA_W-1:FE_DATA_W];  // odd word in upper half
         end else begin
            rd_data <= be_word[FE_DATA_W-1:0];
         end
      end
   end

endmodule

//--- hdl/line_refill.sv
`timescale 1ns/1ps

module line_refill import cache_pkg::*; (
   input  logic                 clk_i,
   input  logic                 reset,
   input  logic                 replace_valid,
   input  fe_addr_u             replace_addr,
   output logic                 replace,
   output logic                 read_valid,
   output logic [LINE2BE_W-1:0] read_addr,
   output logic [BE_DATA_W-1:0] read_rdata,
   output logic [BE_ADDR_W-1:0] be_addr,
   output logic                 be_valid,
   input  logic                 be_ready,
   input  logic                 be_rvalid,
   input  logic [BE_DATA_W-1:0] be_rdata
);

   logic [1:0]           state;
   logic [LINE2BE_W-1:0] word_counter;

   // aligned line base plus the back-end word being fetched
   assign be_addr    = {replace_addr.l.line, word_counter, {BE_NBYTES_W{1'b0}}};
   assign read_rdata = be_rdata;  // returned word goes straight to the store

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         read_addr <= '0;
      end else begin
         read_addr <= word_counter;  // index of the next word to arrive
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= RF_IDLE;
      end else begin
         case (state)
            RF_IDLE: begin
               if (replace_valid && be_ready) begin  // start the burst once memory is ready
                  state <= RF_HANDSHAKE;
               end
            end
            RF_HANDSHAKE: begin
               if (be_rvalid && (&read_addr)) begin  // last word of the line
                  state <= RF_END_HANDSHAKE;
               end
            end
            RF_END_HANDSHAKE: begin
               state <= RF_IDLE;  // one cycle after the last write
            end
            default: begin
               state <= RF_IDLE;
            end
         endcase
      end
   end

   always_comb begin
      be_valid     = 1'b0;
      replace      = 1'b1;
      word_counter = '0;
      read_valid   = 1'b0;
      case (state)
         RF_IDLE: begin
            replace = 1'b0;
         end
         RF_HANDSHAKE: begin
            be_valid     = ~be_rvalid | ~(&read_addr);  // drop after the final word
            word_counter = read_addr + LINE2BE_W'(be_rvalid);
            read_valid   = be_rvalid;
         end
         default: begin
         end
      endcase
   end

   a_no_valid_idle: assert property (@(posedge clk_i) disable iff (reset)
      (state == RF_IDLE) |-> !be_valid)
      else $error("be_valid raised while refill channel idle");

   // memory must not answer a request that was never made
   a_no_rvalid_idle: assert property (@(posedge clk_i) disable iff (reset)
      (state == RF_IDLE) |-> !be_rvalid)
      else $error("be_rvalid arrived while refill channel idle");

endmodule

//--- hdl/tag_store.sv
`timescale 1ns/1ps

module tag_store import cache_pkg::*; (
   input  logic               clk_i,
   input  logic               reset,
   input  logic               invalidate,
   input  logic [INDEX_W-1:0] index,
   input  logic [TAG_W-1:0]   tag,
   input  logic               fill,
   output logic               hit
);

   logic [TAG_W-1:0]   tag_mem [N_LINES];
   logic [N_LINES-1:0] valid;

   always_ff @(posedge clk_i) begin
      if (fill) begin
         tag_mem[index] <= tag;  // new owner of the line
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;  // flush every line at once
      end else if (fill) begin
         valid[index] <= 1'b1;
      end
   end

   // lookup is combinational on the latched address
   assign hit = valid[index] && (tag_mem[index] == tag);

   a_fill_vs_inval: assert property (@(posedge clk_i) disable iff (reset)
      !(fill && invalidate))
      else $error("line fill collided with invalidate");

endmodule

//--- tb/cache_rd_checker.sv
`timescale 1ns/1ps

module cache_rd_checker import cache_pkg::*; (
   input  logic                 clk_i,
   input  logic                 reset,
   input  logic                 req,
   input  logic [FE_ADDR_W-1:0] addr,
   input  logic                 exp_miss,
   input  logic                 invalidate,
   input  logic                 busy,
   input  logic [FE_DATA_W-1:0] rdata,
   input  logic                 rvalid,
   input  logic [BE_ADDR_W-1:0] be_addr,
   input  logic                 be_valid,
   input  logic                 be_ready,
   input  logic                 be_rvalid,
   output int                   err_count,
   output int                   test_count
);

   logic [TAG_W-1:0]     sh_tag [N_LINES];  // shadow of the tag store
   logic [N_LINES-1:0]   sh_valid;
   logic [FE_ADDR_W-1:0] acc_addr;
   logic                 acc_exp_miss;
   logic                 pred_miss;
   logic                 in_flight;
   logic                 outstanding;  // back-end word requested and not yet returned
   logic [BE_ADDR_W-1:0] held_addr;
   logic                 prev_be_valid;
   logic                 prev_be_ready;
   int                   burst_n;
   int                   lat;
   int                   test_err;

   function automatic logic [INDEX_W-1:0] index_of(input logic [FE_ADDR_W-1:0] a);
      return a[FE_BYTE_W+WORD_OFFSET_W +: INDEX_W];
   endfunction

   function automatic logic [TAG_W-1:0] tag_of(input logic [FE_ADDR_W-1:0] a);
      return a[FE_ADDR_W-1 -: TAG_W];
   endfunction

   // memory returns base+1 in the low half and base+2 in the high half
   function automatic logic [FE_DATA_W-1:0] expect_word(input logic [FE_ADDR_W-1:0] a);
      logic [FE_DATA_W-1:0] base;
      base = FE_DATA_W'({a[FE_ADDR_W-1:BE_NBYTES_W], {BE_NBYTES_W{1'b0}}});
      if (a[FE_BYTE_W]) begin
         return base + 2;  // odd front-end word
      end
      return base + 1;
   endfunction

   function automatic logic [BE_ADDR_W-1:0] burst_addr(input logic [FE_ADDR_W-1:0] a,
                                                       input int k);
      logic [BE_ADDR_W-1:0] line_base;
      line_base = {a[FE_ADDR_W-1:FE_BYTE_W+WORD_OFFSET_W], {(FE_BYTE_W+WORD_OFFSET_W){1'b0}}};
      return line_base + BE_ADDR_W'(k << BE_NBYTES_W);
   endfunction

   task automatic report_fail(input string msg);
      $display("Fail %0t ns: %s", $time, msg);
      err_count++;
      test_err++;
   endtask

   task automatic check_backend();
      logic [BE_ADDR_W-1:0] want;
      want = burst_addr(acc_addr, burst_n);
      if (be_rvalid) begin
         outstanding = 1'b0;
      end else if (be_valid && !outstanding) begin
         outstanding = 1'b1;  // a new back-end word is being asked for
         held_addr   = be_addr;
         if (!in_flight) begin
            report_fail("back-end request while no read was in flight");
         end else if (burst_n >= (1 << LINE2BE_W)) begin
            report_fail("more back-end requests than one line holds");
         end else if (be_addr != want) begin
            report_fail($sformatf("be_addr 0x%h, expected 0x%h", be_addr, want));
         end
         if (!prev_be_valid && !prev_be_ready) begin
            report_fail("refill began while be_ready was low");
         end
         burst_n++;
      end else if (be_valid && (be_addr != held_addr)) begin
         report_fail($sformatf("be_addr moved to 0x%h while waiting for data", be_addr));
      end
      prev_be_valid = be_valid;
      prev_be_ready = be_ready;
   endtask

   task automatic finish_read();
      logic [FE_DATA_W-1:0] want;
      logic                 miss_seen;
      want      = expect_word(acc_addr);
      miss_seen = (burst_n != 0);
      if (rdata !== want) begin
         report_fail($sformatf("rdata 0x%h for 0x%h, expected 0x%h", rdata, acc_addr, want));
      end
      if (miss_seen && (burst_n != (1 << LINE2BE_W))) begin
         report_fail($sformatf("refill made %0d back-end requests", burst_n));
      end
      if (miss_seen != pred_miss) begin
         report_fail("hit or miss differs from the tag shadow");
      end
      if (miss_seen != acc_exp_miss) begin
         report_fail("hit or miss differs from the stimulus table");
      end
      // answer is visible from E0+2 and is seen at the third edge
      if (!miss_seen && (lat != 3)) begin
         report_fail($sformatf("hit answered after %0d edges, expected 3", lat));
      end
      if (pred_miss) begin
         sh_valid[index_of(acc_addr)] = 1'b1;
         sh_tag[index_of(acc_addr)]   = tag_of(acc_addr);
      end
      in_flight = 1'b0;
      test_count++;
      $display("test %0d read 0x%h %s after %0d edges: %s", test_count, acc_addr,
               miss_seen ? "miss" : "hit", lat, (test_err == 0) ? "ok" : "errors");
   endtask

   always @(posedge clk_i or posedge reset) begin
      if (reset) begin
         sh_valid      = '0;
         in_flight     = 1'b0;
         outstanding   = 1'b0;
         prev_be_valid = 1'b0;
         prev_be_ready = 1'b0;
         err_count     = 0;
         test_count    = 0;
      end else begin
         check_backend();
         if (invalidate && !busy) begin
            sh_valid = '0;  // flush lands before a lookup taken at this edge
            test_count++;
            $display("test %0d invalidate: ok", test_count);
         end
         if (in_flight) begin
            lat++;
            if (rvalid) begin
               finish_read();
            end else if (!busy) begin
               report_fail("busy dropped before the answer arrived");
            end
         end else if (rvalid) begin
            report_fail("rvalid with no read in flight");
         end
         if (req && !busy) begin
            acc_addr     = addr;
            acc_exp_miss = exp_miss;
            pred_miss    = !(sh_valid[index_of(addr)] && (sh_tag[index_of(addr)] == tag_of(addr)));
            in_flight    = 1'b1;
            lat          = 0;
            burst_n      = 0;
            test_err     = 0;
         end
      end
   end

endmodule

//--- tb/cache_rd_tb.sv
`timescale 1ns/1ps

module cache_rd_tb import cache_pkg::*; ();

   typedef struct packed {
      logic                 is_inval;
      logic [FE_ADDR_W-1:0] addr;
      logic                 miss;
      logic [3:0]           stall;  // cycles of be_ready low after the request
   } row_t;

   logic                 clk_i;
   logic                 reset;
   logic                 req;
   logic [FE_ADDR_W-1:0] addr;
   logic                 invalidate;
   logic                 exp_miss;
   logic                 busy;
   logic [FE_DATA_W-1:0] rdata;
   logic                 rvalid;
   logic [BE_ADDR_W-1:0] be_addr;
   logic                 be_valid;
   logic                 be_ready;
   logic                 be_rvalid = 1'b0;
   logic [BE_DATA_W-1:0] be_rdata = '0;
   logic [BE_ADDR_W-1:0] mem_addr;
   logic                 mem_busy = 1'b0;
   int                   mem_wait;
   int                   err_count;
   int                   test_count;
   int                   tb_errors;
   int                   cur_row;
   int                   wait_limit = 200;
   logic                 timed_out;
   row_t                 rows [$];

   cache_rd_top dut (
      .clk_i      (clk_i),
      .reset      (reset),
      .req        (req),
      .addr       (addr),
      .invalidate (invalidate),
      .busy       (busy),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .be_addr    (be_addr),
      .be_valid   (be_valid),
      .be_ready   (be_ready),
      .be_rvalid  (be_rvalid),
      .be_rdata   (be_rdata)
   );

   cache_rd_checker chk (
      .clk_i      (clk_i),
      .reset      (reset),
      .req        (req),
      .addr       (addr),
      .exp_miss   (exp_miss),
      .invalidate (invalidate),
      .busy       (busy),
      .rdata      (rdata),
      .rvalid     (rvalid),
      .be_addr    (be_addr),
      .be_valid   (be_valid),
      .be_ready   (be_ready),
      .be_rvalid  (be_rvalid),
      .err_count  (err_count),
      .test_count (test_count)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // back-end memory answers one word per request after 0 to 3 idle cycles
   always @(negedge clk_i) begin
      if (be_rvalid) begin
         be_rvalid = 1'b0;
      end else if (mem_busy) begin
         if (mem_wait == 0) begin
            be_rdata  = {FE_DATA_W'(mem_addr) + 32'd2, FE_DATA_W'(mem_addr) + 32'd1};
            be_rvalid = 1'b1;
            mem_busy  = 1'b0;
         end else begin
            mem_wait--;
         end
      end else if (be_valid) begin
         mem_addr = be_addr;
         mem_wait = int'($urandom % 4);
         mem_busy = 1'b1;
      end
   end

   task automatic add_row(input logic is_inval, input logic [FE_ADDR_W-1:0] a,
                          input logic miss, input int stall);
      row_t r;
      r.is_inval = is_inval;
      r.addr     = a;
      r.miss     = miss;
      r.stall    = 4'(stall);
      rows.push_back(r);
   endtask

   task automatic build_table();
      int w;
      add_row(1'b0, 16'h0040, 1'b1, 0);  // cold line at index 2
      add_row(1'b0, 16'h0044, 1'b0, 0);
      add_row(1'b0, 16'h005C, 1'b0, 0);
      add_row(1'b0, 16'h0048, 1'b0, 0);
      add_row(1'b0, 16'h0240, 1'b1, 0);  // index 2 with another tag
      add_row(1'b0, 16'h0250, 1'b0, 0);
      add_row(1'b0, 16'h004C, 1'b1, 0);  // old tag was evicted
      add_row(1'b0, 16'h1A60, 1'b1, 0);
      add_row(1'b0, 16'h1A78, 1'b0, 0);
      add_row(1'b1, 16'h0000, 1'b0, 0);
      add_row(1'b0, 16'h0054, 1'b1, 0);
      add_row(1'b0, 16'h1A64, 1'b1, 0);
      add_row(1'b0, 16'h3F80, 1'b1, 5);  // memory not ready for a while
      add_row(1'b0, 16'h3F9C, 1'b0, 0);
      add_row(1'b0, 16'h7E00, 1'b1, 3);
      add_row(1'b0, 16'h7E1C, 1'b0, 0);
      add_row(1'b0, 16'h3F84, 1'b0, 0);
      add_row(1'b0, 16'hFFE0, 1'b1, 2);
      for (w = 1; w < 8; w++) begin
         add_row(1'b0, 16'hFFE0 + 16'(w * 4), 1'b0, 0);  // every word of the line
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && (n < wait_limit)) begin
         @(negedge clk_i);
         n++;
      end
      if (busy) begin
         $display("timeout: DUT still busy before table row %0d", cur_row);
         tb_errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_answer();
      int n;
      n = 0;
      while (!rvalid && (n < wait_limit)) begin
         @(negedge clk_i);
         n++;
      end
      if (!rvalid) begin
         $display("timeout: no rvalid for table row %0d", cur_row);
         tb_errors++;
         timed_out = 1'b1;
      end else begin
         @(negedge clk_i);
      end
   endtask

   task automatic run_read(input logic [FE_ADDR_W-1:0] a, input logic miss, input int stall);
      int n;
      wait_idle();
      if (!timed_out) begin
         be_ready = (stall == 0);
         addr     = a;
         exp_miss = miss;
         req      = 1'b1;
         @(negedge clk_i);
         req = 1'b0;
         for (n = 0; n < stall; n++) begin
            req  = (n == 1);  // stray request to another line while the refill waits
            addr = a ^ 16'h0100;
            @(negedge clk_i);
         end
         req      = 1'b0;
         be_ready = 1'b1;
         wait_answer();
      end
   endtask

   task automatic run_invalidate();
      wait_idle();
      if (!timed_out) begin
         invalidate = 1'b1;
         @(negedge clk_i);
         invalidate = 1'b0;
         @(negedge clk_i);
      end
   endtask

   initial begin
      row_t row;
      int   i;
      void'($urandom(82936));
      reset      = 1'b1;
      req        = 1'b0;
      addr       = '0;
      invalidate = 1'b0;
      exp_miss   = 1'b0;
      be_ready   = 1'b1;
      tb_errors  = 0;
      timed_out  = 1'b0;
      cur_row    = 0;
      build_table();
      repeat (5) @(negedge clk_i);
      reset = 1'b0;
      @(negedge clk_i);
      for (i = 0; (i < rows.size()) && !timed_out; i++) begin
         row     = rows[i];
         cur_row = i + 1;
         if (row.is_inval) begin
            run_invalidate();
         end else begin
            run_read(row.addr, row.miss, int'(row.stall));
         end
      end
      @(negedge clk_i);
      if (!timed_out && (test_count != rows.size())) begin
         $display("checker finished %0d tests but the table has %0d", test_count, rows.size());
         tb_errors++;
      end
      $display("tests %0d, check errors %0d, testbench errors %0d",
               test_count, err_count, tb_errors);
      if ((err_count == 0) && (tb_errors == 0)) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
